/* files.f */
+incdir+logic
logic/ctrl_pkg.sv
logic/ctrl_exc_select.sv
logic/ctrl_fsm.sv
logic/ctrl_top.sv
tb/ctrl_props.sv
tb/ctrl_tb.sv

/* Makefile */
# Verilator flow for the decode controller testbench

VERILATOR ?= verilator
TOP       ?= ctrl_tb
FILE_LIST ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert --timescale 1ns/1ps
PASS_MSG  ?= Simulation passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILE_LIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILE_LIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tb/ctrl_tb.sv */
////////////////////////////////////////////////////////////
// random testbench for the decode controller
// a cycle model predicts the control outputs at each falling
// edge, decoder flags are held while the model is in flush
////////////////////////////////////////////////////////////

`default_nettype none
`timescale 1ns/1ps

`include "ctrl_defines.svh"

module ctrl_tb;

  // model states
  localparam int S_RESET   = 0;
  localparam int S_BOOT    = 1;
  localparam int S_WSLEEP  = 2;
  localparam int S_SLEEP   = 3;
  localparam int S_FFETCH  = 4;
  localparam int S_DECODE  = 5;
  localparam int S_FLUSH   = 6;
  localparam int S_IRQ     = 7;

  localparam int BOOT_TIMEOUT = 100;
  localparam int NUM_CYCLES   = 4000;

  logic clk_i;
  logic rst_ni;

  // DUT inputs
  logic fetch_enable_i, illegal_insn_i, ecall_insn_i, ebrk_insn_i;
  logic mret_insn_i, wfi_insn_i, csr_status_i, instr_valid_i;
  logic load_err_i, store_err_i, branch_set_i, jump_set_i;
  logic stall_lsu_i, stall_multdiv_i, stall_jump_i, stall_branch_i;
  logic irq_i, irq_req_i, m_ie_i;
  logic [`CTRL_XLEN-1:0]     instr_i;
  logic [`CTRL_XLEN-1:0]     lsu_addr_last_i;
  logic [`CTRL_IRQ_ID_W-1:0] irq_id_i;

  // DUT outputs
  logic ctrl_busy_o, first_fetch_o, instr_req_o, pc_set_o;
  logic id_in_ready_o, instr_valid_clear_o, id_out_valid_o;
  ctrl_pkg::pc_sel_e         pc_mux_o;
  ctrl_pkg::exc_pc_sel_e     exc_pc_mux_o;
  logic irq_ack_o, exc_ack_o;
  logic [`CTRL_IRQ_ID_W-1:0] irq_id_o;
  ctrl_pkg::cause_u          exc_cause_o;
  logic [`CTRL_XLEN-1:0]     csr_mtval_o;
  logic csr_save_if_o, csr_save_id_o, csr_save_cause_o, csr_restore_mret_o;

  // model state, lsu error copies and pending interrupt
  int   st;
  int   nxt;
  logic load_q_m, store_q_m, load_q_nxt, store_q_nxt;
  logic irq_pend, ack_seen;

  int seed = 39673;
  int mismatches;
  int failures;
  int cycles;
  int n_jump, n_exc, n_lsu_exc, n_mret, n_wake, n_irq;

  ctrl_top i_ctrl_top (.*);

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  function automatic int unsigned rand_below(int unsigned n);
    return {$random(seed)} % n;
  endfunction

  task automatic check_bit(input string name, input logic got, input logic exp);
    assert (got === exp) else begin
      mismatches++;
      $display("Mismatch %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_word(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
    assert (got === exp) else begin
      mismatches++;
      $display("Mismatch %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic require_seen(input string what, input int count);
    assert (count > 0) else begin
      failures++;
      $display("no %s was seen during the random run", what);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////

  task automatic drive_inputs(input bit boot);
    logic [2:0] combo;
    if (boot) begin
      fetch_enable_i <= (rand_below(3) == 0);
    end else begin
      fetch_enable_i <= 1'b1;
    end
    // the decoder keeps its word through the flush cycle
    if (st != S_FLUSH) begin
      illegal_insn_i <= 1'b0;
      ecall_insn_i   <= 1'b0;
      ebrk_insn_i    <= 1'b0;
      mret_insn_i    <= 1'b0;
      wfi_insn_i     <= 1'b0;
      csr_status_i   <= 1'b0;
      case (rand_below(24))
        0: illegal_insn_i <= 1'b1;
        1: ecall_insn_i   <= 1'b1;
        2: ebrk_insn_i    <= 1'b1;
        3: mret_insn_i    <= 1'b1;
        4: wfi_insn_i     <= 1'b1;
        5: csr_status_i   <= 1'b1;
        6: begin
          // several exception flags at once
          combo = 3'(rand_below(8));
          illegal_insn_i <= combo[0];
          ecall_insn_i   <= combo[1];
          ebrk_insn_i    <= combo[2];
        end
        default: ;
      endcase
      instr_i       <= $random(seed);
      instr_valid_i <= (rand_below(8) != 0);
    end
    lsu_addr_last_i <= $random(seed);
    load_err_i      <= (rand_below(30) == 0);
    store_err_i     <= (rand_below(30) == 0);
    branch_set_i    <= (rand_below(12) == 0);
    jump_set_i      <= (rand_below(12) == 0);
    stall_lsu_i     <= (rand_below(10) == 0);
    stall_multdiv_i <= (rand_below(10) == 0);
    stall_jump_i    <= (rand_below(10) == 0);
    stall_branch_i  <= (rand_below(10) == 0);
    m_ie_i          <= (rand_below(4) != 0);
    // a request stays up until its ack pulse
    if (ack_seen) begin
      irq_pend = 1'b0;
    end
    if (!irq_pend && rand_below(12) == 0) begin
      irq_pend = 1'b1;
      irq_id_i <= 5'(rand_below(32));
    end
    irq_req_i <= irq_pend;
    irq_i     <= irq_pend | (rand_below(16) == 0);
  endtask

  ////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////

  task automatic predict_and_check();
    logic stall, special, exc, take_irq, halt_if, halt_id;
    logic e_busy, e_req, e_ff, e_set, e_ack, e_restore;
    logic e_save_if, e_save_id, e_save_cause;
    ctrl_pkg::pc_sel_e       e_mux;
    ctrl_pkg::exc_pc_sel_e   e_emux;
    logic [`CTRL_CAUSE_W-1:0] e_cause;
    logic [`CTRL_XLEN-1:0]   e_mtval;

    stall    = stall_lsu_i | stall_multdiv_i | stall_jump_i | stall_branch_i;
    exc      = illegal_insn_i | ecall_insn_i | ebrk_insn_i | load_q_m | store_q_m;
    special  = exc | mret_insn_i | wfi_insn_i | csr_status_i | load_err_i | store_err_i;
    take_irq = irq_req_i & m_ie_i;
    halt_if  = 1'b0;
    halt_id  = 1'b0;
    e_busy   = 1'b1;
    e_req    = 1'b1;
    e_ff     = 1'b0;
    e_set    = 1'b0;
    e_ack    = 1'b0;
    e_restore = 1'b0;
    e_save_if = 1'b0;
    e_save_id = 1'b0;
    e_save_cause = 1'b0;
    e_mux    = ctrl_pkg::PC_BOOT;
    e_emux   = ctrl_pkg::EXC_PC_EXC;
    nxt      = st;

    case (st)
      S_RESET: begin
        e_req = 1'b0;
        e_set = 1'b1;
        if (fetch_enable_i) nxt = S_BOOT;
      end
      S_BOOT: begin
        e_set = 1'b1;
        nxt   = S_FFETCH;
      end
      S_WSLEEP, S_SLEEP: begin
        e_busy  = 1'b0;
        e_req   = 1'b0;
        halt_if = 1'b1;
        halt_id = 1'b1;
        if (st == S_WSLEEP) nxt = S_SLEEP;
        else if (irq_i) nxt = S_FFETCH;
      end
      S_FFETCH: begin
        e_ff = 1'b1;
        if (take_irq) begin
          nxt     = S_IRQ;
          halt_if = 1'b1;
          halt_id = 1'b1;
        end else if (!stall) begin
          nxt = S_DECODE;
        end
      end
      S_DECODE: begin
        if (instr_valid_i && (branch_set_i || jump_set_i)) begin
          e_set = 1'b1;
          e_mux = ctrl_pkg::PC_JUMP;
        end else if (instr_valid_i && special) begin
          nxt     = S_FLUSH;
          halt_if = 1'b1;
          halt_id = 1'b1;
        end
        // a stalled interrupt only holds IF
        if (instr_valid_i && take_irq && stall) halt_if = 1'b1;
        if (!stall && !special && take_irq) begin
          nxt     = S_IRQ;
          halt_if = 1'b1;
          halt_id = 1'b1;
        end
      end
      S_FLUSH: begin
        halt_if = 1'b1;
        halt_id = 1'b1;
        nxt     = S_DECODE;
        if (exc) begin
          e_set        = 1'b1;
          e_mux        = ctrl_pkg::PC_EXC;
          e_save_id    = 1'b1;
          e_save_cause = 1'b1;
        end else if (mret_insn_i) begin
          e_set     = 1'b1;
          e_mux     = ctrl_pkg::PC_ERET;
          e_restore = 1'b1;
        end else if (wfi_insn_i) begin
          nxt = S_WSLEEP;
        end
      end
      default: begin
        e_set        = 1'b1;
        e_mux        = ctrl_pkg::PC_EXC;
        e_emux       = ctrl_pkg::EXC_PC_IRQ;
        e_save_if    = 1'b1;
        e_save_cause = 1'b1;
        e_ack        = 1'b1;
        nxt          = S_DECODE;
      end
    endcase

    // cause codes: illegal 02, ecall 0b, ebreak 03, store 07, load 05
    e_mtval = '0;
    if (st == S_IRQ) begin
      e_cause = {1'b1, irq_id_i};
    end else if (illegal_insn_i) begin
      e_cause = 6'h02;
      e_mtval = instr_i;
    end else if (ecall_insn_i) begin
      e_cause = 6'h0B;
    end else if (ebrk_insn_i) begin
      e_cause = 6'h03;
    end else if (store_q_m) begin
      e_cause = 6'h07;
      e_mtval = lsu_addr_last_i;
    end else if (load_q_m) begin
      e_cause = 6'h05;
      e_mtval = lsu_addr_last_i;
    end else begin
      e_cause = 6'h00;
    end

    check_bit("ctrl_busy_o", ctrl_busy_o, e_busy);
    check_bit("instr_req_o", instr_req_o, e_req);
    check_bit("first_fetch_o", first_fetch_o, e_ff);
    check_bit("id_in_ready_o", id_in_ready_o, ~stall & ~halt_if);
    check_bit("instr_valid_clear_o", instr_valid_clear_o, ~stall | halt_id);
    check_bit("id_out_valid_o", id_out_valid_o, ~stall & instr_valid_i & ~special);
    check_bit("pc_set_o", pc_set_o, e_set);
    check_bit("irq_ack_o", irq_ack_o, e_ack);
    check_bit("exc_ack_o", exc_ack_o, e_ack);
    check_bit("csr_save_if_o", csr_save_if_o, e_save_if);
    check_bit("csr_save_id_o", csr_save_id_o, e_save_id);
    check_bit("csr_save_cause_o", csr_save_cause_o, e_save_cause);
    check_bit("csr_restore_mret_o", csr_restore_mret_o, e_restore);
    check_word("irq_id_o", 32'(irq_id_o), 32'(irq_id_i));
    if (e_set) check_word("pc_mux_o", 32'(pc_mux_o), 32'(e_mux));
    if (e_set && e_mux == ctrl_pkg::PC_EXC) begin
      check_word("exc_pc_mux_o", 32'(exc_pc_mux_o), 32'(e_emux));
    end
    if (e_save_cause) check_word("exc_cause_o", 32'(exc_cause_o), 32'(e_cause));
    if (e_save_id) check_word("csr_mtval_o", csr_mtval_o, e_mtval);

    if (e_set && e_mux == ctrl_pkg::PC_JUMP) n_jump++;
    if (e_save_id) n_exc++;
    if (e_save_id && (e_cause == 6'h05 || e_cause == 6'h07)) n_lsu_exc++;
    if (e_restore) n_mret++;
    if (st == S_SLEEP && irq_i) n_wake++;
    if (e_ack) n_irq++;
    ack_seen    = e_ack;
    load_q_nxt  = load_err_i;
    store_q_nxt = store_err_i;
  endtask

  // one clock: commit the model, drive new inputs, check at the low phase
  task automatic run_cycle(input bit boot);
    @(posedge clk_i);
    st        = nxt;
    load_q_m  = load_q_nxt;
    store_q_m = store_q_nxt;
    drive_inputs(boot);
    @(negedge clk_i);
    predict_and_check();
  endtask

  initial begin
    rst_ni = 1'b0;
    {fetch_enable_i, illegal_insn_i, ecall_insn_i, ebrk_insn_i} = '0;
    {mret_insn_i, wfi_insn_i, csr_status_i, instr_valid_i} = '0;
    {load_err_i, store_err_i, branch_set_i, jump_set_i} = '0;
    {stall_lsu_i, stall_multdiv_i, stall_jump_i, stall_branch_i} = '0;
    {irq_i, irq_req_i, m_ie_i} = '0;
    instr_i         = '0;
    lsu_addr_last_i = '0;
    irq_id_i        = '0;
    nxt             = S_RESET;
    load_q_nxt      = 1'b0;
    store_q_nxt     = 1'b0;
    irq_pend        = 1'b0;
    ack_seen        = 1'b0;
    repeat (3) @(posedge clk_i);
    rst_ni <= 1'b1;

    // boot, fetch enable arrives at a random cycle
    cycles = 0;
    while (st != S_DECODE && failures == 0) begin
      run_cycle(1'b1);
      cycles++;
      if (cycles >= BOOT_TIMEOUT) begin
        failures++;
        $display("boot did not reach decode within %0d cycles", BOOT_TIMEOUT);
      end
    end

    repeat (NUM_CYCLES) run_cycle(1'b0);

    require_seen("branch or jump redirect", n_jump);
    require_seen("exception entry", n_exc);
    require_seen("LSU access fault", n_lsu_exc);
    require_seen("MRET return", n_mret);
    require_seen("wake-up from sleep", n_wake);
    require_seen("interrupt acknowledge", n_irq);

    $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tb/ctrl_props.sv */
////////////////////////////////////////////////////////////
// output properties of the controller FSM, bound into ctrl_fsm
// the sleep flag is formed from the private state enum
////////////////////////////////////////////////////////////

`default_nettype none
`timescale 1ns/1ps

module ctrl_props (
  input wire logic       clk_i,
  input wire logic       rst_ni,
  input wire logic       pc_set_i,
  input wire logic [1:0] pc_mux_i,
  input wire logic       csr_save_cause_i,
  input wire logic       irq_ack_i,
  input wire logic       exc_ack_i,
  input wire logic       irq_i,
  input wire logic       first_fetch_i,
  input wire logic       in_sleep_i
);

  // every trap entry records its cause
  a_exc_saves_cause: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (pc_set_i && pc_mux_i == ctrl_pkg::PC_EXC) |-> csr_save_cause_i)
    else $error("exception pc set without cause save");

  a_irq_ack_exc_ack: assert property (@(posedge clk_i) disable iff (!rst_ni)
    irq_ack_i |-> exc_ack_i)
    else $error("irq ack without exception ack");

  // any interrupt line wakes the core
  a_sleep_wake: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (in_sleep_i && irq_i) |=> first_fetch_i)
    else $error("no first fetch after wake-up from sleep");

endmodule

bind ctrl_fsm ctrl_props i_props (
  .clk_i            (clk_i),
  .rst_ni           (rst_ni),
  .pc_set_i         (pc_set_o),
  .pc_mux_i         (pc_mux_o),
  .csr_save_cause_i (csr_save_cause_o),
  .irq_ack_i        (irq_ack_o),
  .exc_ack_i        (exc_ack_o),
  .irq_i            (irq_i),
  .first_fetch_i    (first_fetch_o),
  .in_sleep_i       (ctrl_fsm_cs == SLEEP)
);

`default_nettype wire

/* logic/ctrl_top.sv */
////////////////////////////////////////////////////////////
// decode controller top, exception select plus state machine
// irq_id_o echoes irq_id_i without a register
////////////////////////////////////////////////////////////

`default_nettype none
`timescale 1ns/1ps

`include "ctrl_defines.svh"

module ctrl_top (
  input  wire logic                      clk_i,
  input  wire logic                      rst_ni,

  input  wire logic                      fetch_enable_i,
  output logic                           ctrl_busy_o,
  output logic                           first_fetch_o,

  // decoder
  input  wire logic                      illegal_insn_i,
  input  wire logic                      ecall_insn_i,
  input  wire logic                      ebrk_insn_i,
  input  wire logic                      mret_insn_i,
  input  wire logic                      wfi_insn_i,
  input  wire logic                      csr_status_i,

  // IF-ID register
  input  wire logic                      instr_valid_i,
  input  wire logic [`CTRL_XLEN-1:0]     instr_i,
  output logic                           id_in_ready_o,
  output logic                           instr_valid_clear_o,
  output logic                           id_out_valid_o,

  // prefetcher
  output logic                           instr_req_o,
  output logic                           pc_set_o,
  output ctrl_pkg::pc_sel_e              pc_mux_o,
  output ctrl_pkg::exc_pc_sel_e          exc_pc_mux_o,

  // lsu
  input  wire logic [`CTRL_XLEN-1:0]     lsu_addr_last_i,
  input  wire logic                      load_err_i,
  input  wire logic                      store_err_i,

  input  wire logic                      branch_set_i,
  input  wire logic                      jump_set_i,

  input  wire logic                      stall_lsu_i,
  input  wire logic                      stall_multdiv_i,
  input  wire logic                      stall_jump_i,
  input  wire logic                      stall_branch_i,

  // interrupts
  input  wire logic                      irq_i,
  input  wire logic                      irq_req_i,
  input  wire logic [`CTRL_IRQ_ID_W-1:0] irq_id_i,
  input  wire logic                      m_ie_i,
  output logic                           irq_ack_o,
  output logic [`CTRL_IRQ_ID_W-1:0]      irq_id_o,

  // trap csr
  output ctrl_pkg::cause_u               exc_cause_o,
  output logic                           exc_ack_o,
  output logic [`CTRL_XLEN-1:0]          csr_mtval_o,
  output logic                           csr_save_if_o,
  output logic                           csr_save_id_o,
  output logic                           csr_save_cause_o,
  output logic                           csr_restore_mret_o
);

  logic exc_req;
  logic special_req;
  logic irq_taken;

  assign irq_id_o = irq_id_i;

  ctrl_exc_select i_exc_select (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .illegal_insn_i  (illegal_insn_i),
    .ecall_insn_i    (ecall_insn_i),
    .ebrk_insn_i     (ebrk_insn_i),
    .mret_insn_i     (mret_insn_i),
    .wfi_insn_i      (wfi_insn_i),
    .csr_status_i    (csr_status_i),
    .load_err_i      (load_err_i),
    .store_err_i     (store_err_i),
    .instr_i         (instr_i),
    .lsu_addr_last_i (lsu_addr_last_i),
    .irq_id_i        (irq_id_i),
    .irq_taken_i     (irq_taken),
    .exc_req_o       (exc_req),
    .special_req_o   (special_req),
    .exc_cause_o     (exc_cause_o),
    .csr_mtval_o     (csr_mtval_o)
  );

  ctrl_fsm i_fsm (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .fetch_enable_i      (fetch_enable_i),
    .instr_valid_i       (instr_valid_i),
    .branch_set_i        (branch_set_i),
    .jump_set_i          (jump_set_i),
    .stall_lsu_i         (stall_lsu_i),
    .stall_multdiv_i     (stall_multdiv_i),
    .stall_jump_i        (stall_jump_i),
    .stall_branch_i      (stall_branch_i),
    .irq_i               (irq_i),
    .irq_req_i           (irq_req_i),
    .m_ie_i              (m_ie_i),
    .mret_insn_i         (mret_insn_i),
    .wfi_insn_i          (wfi_insn_i),
    .exc_req_i           (exc_req),
    .special_req_i       (special_req),
    .ctrl_busy_o         (ctrl_busy_o),
    .first_fetch_o       (first_fetch_o),
    .instr_req_o         (instr_req_o),
    .id_in_ready_o       (id_in_ready_o),
    .instr_valid_clear_o (instr_valid_clear_o),
    .id_out_valid_o      (id_out_valid_o),
    .pc_set_o            (pc_set_o),
    .pc_mux_o            (pc_mux_o),
    .exc_pc_mux_o        (exc_pc_mux_o),
    .irq_ack_o           (irq_ack_o),
    .exc_ack_o           (exc_ack_o),
    .irq_taken_o         (irq_taken),
    .csr_save_if_o       (csr_save_if_o),
    .csr_save_id_o       (csr_save_id_o),
    .csr_save_cause_o    (csr_save_cause_o),
    .csr_restore_mret_o  (csr_restore_mret_o)
  );

endmodule

`default_nettype wire

/* logic/ctrl_fsm.sv */
////////////////////////////////////////////////////////////
// main decode controller state machine
// priority is running instruction, then exception, then irq
// the decoder inputs must hold through the flush cycle
////////////////////////////////////////////////////////////

`default_nettype none
`timescale 1ns/1ps

module ctrl_fsm (
  input  wire logic           clk_i,
  input  wire logic           rst_ni,

  input  wire logic           fetch_enable_i,
  input  wire logic           instr_valid_i,
  input  wire logic           branch_set_i,
  input  wire logic           jump_set_i,

  // multicycle stalls from execute
  input  wire logic           stall_lsu_i,
  input  wire logic           stall_multdiv_i,
  input  wire logic           stall_jump_i,
  input  wire logic           stall_branch_i,

  // irq_i wakes from sleep even when the irq is not taken
  input  wire logic           irq_i,
  input  wire logic           irq_req_i,
  input  wire logic           m_ie_i,

  input  wire logic           mret_insn_i,
  input  wire logic           wfi_insn_i,
  input  wire logic           exc_req_i,
  input  wire logic           special_req_i,

  output logic                ctrl_busy_o,
  output logic                first_fetch_o,
  output logic                instr_req_o,

  // IF-ID register control
  output logic                id_in_ready_o,
  output logic                instr_valid_clear_o,
  output logic                id_out_valid_o,

  output logic                pc_set_o,
  output ctrl_pkg::pc_sel_e   pc_mux_o,
  output ctrl_pkg::exc_pc_sel_e exc_pc_mux_o,

  output logic                irq_ack_o,
  output logic                exc_ack_o,
  output logic                irq_taken_o,

  output logic                csr_save_if_o,
  output logic                csr_save_id_o,
  output logic                csr_save_cause_o,
  output logic                csr_restore_mret_o
);

  typedef enum logic [2:0] {
    RESET,
    BOOT_SET,
    WAIT_SLEEP,
    SLEEP,
    FIRST_FETCH,
    DECODE,
    FLUSH,
    IRQ_TAKEN
  } ctrl_fsm_e;

  ctrl_fsm_e ctrl_fsm_cs;
  ctrl_fsm_e ctrl_fsm_ns;

  logic stall;
  logic halt_if;
  logic halt_id;
  logic handle_irq;

  // only enabled machine interrupts are taken
  assign handle_irq  = irq_req_i & m_ie_i;
  assign irq_taken_o = (ctrl_fsm_cs == IRQ_TAKEN);

  ////////////////////////////////////////////////////////////
  // next state and outputs
  ////////////////////////////////////////////////////////////

  always_comb begin
    ctrl_fsm_ns        = ctrl_fsm_cs;
    instr_req_o        = 1'b1;
    ctrl_busy_o        = 1'b1;
    first_fetch_o      = 1'b0;
    pc_set_o           = 1'b0;
    pc_mux_o           = ctrl_pkg::PC_BOOT;
    exc_pc_mux_o       = ctrl_pkg::EXC_PC_IRQ;
    irq_ack_o          = 1'b0;
    exc_ack_o          = 1'b0;
    csr_save_if_o      = 1'b0;
    csr_save_id_o      = 1'b0;
    csr_save_cause_o   = 1'b0;
    csr_restore_mret_o = 1'b0;
    halt_if            = 1'b0;
    halt_id            = 1'b0;

    unique case (ctrl_fsm_cs)
      RESET: begin
        // boot address is presented until fetch is enabled
        instr_req_o = 1'b0;
        pc_set_o    = 1'b1;
        if (fetch_enable_i) begin
          ctrl_fsm_ns = BOOT_SET;
        end
      end

      BOOT_SET: begin
        pc_set_o    = 1'b1;
        ctrl_fsm_ns = FIRST_FETCH;
      end

      WAIT_SLEEP: begin
        ctrl_busy_o = 1'b0;
        instr_req_o = 1'b0;
        halt_if     = 1'b1;
        halt_id     = 1'b1;
        ctrl_fsm_ns = SLEEP;
      end

      SLEEP: begin
        // any interrupt line wakes, taken or not
        ctrl_busy_o = 1'b0;
        instr_req_o = 1'b0;
        halt_if     = 1'b1;
        halt_id     = 1'b1;
        if (irq_i) begin
          ctrl_fsm_ns = FIRST_FETCH;
        end
      end

      FIRST_FETCH: begin
        first_fetch_o = 1'b1;
        // pipeline is empty here, an irq goes first
        if (handle_irq) begin
          ctrl_fsm_ns = IRQ_TAKEN;
          halt_if     = 1'b1;
          halt_id     = 1'b1;
        end else if (!stall) begin
          // IF miss keeps us here
          ctrl_fsm_ns = DECODE;
        end
      end

      DECODE: begin
        if (instr_valid_i) begin
          if (branch_set_i || jump_set_i) begin
            // redirect in the same cycle
            pc_mux_o = ctrl_pkg::PC_JUMP;
            pc_set_o = 1'b1;
          end else if (special_req_i) begin
            ctrl_fsm_ns = FLUSH;
            halt_if     = 1'b1;
            halt_id     = 1'b1;
          end

          // hold IF so a pending irq is not starved by a multicycle op
          if (handle_irq && stall) begin
            halt_if = 1'b1;
          end
        end

        if (!stall && !special_req_i && handle_irq) begin
          ctrl_fsm_ns = IRQ_TAKEN;
          halt_if     = 1'b1;
          halt_id     = 1'b1;
        end
      end

      FLUSH: begin
        halt_if     = 1'b1;
        halt_id     = 1'b1;
        ctrl_fsm_ns = DECODE;

        if (exc_req_i) begin
          // save decode pc and cause, jump to the exception vector
          pc_set_o         = 1'b1;
          pc_mux_o         = ctrl_pkg::PC_EXC;
          exc_pc_mux_o     = ctrl_pkg::EXC_PC_EXC;
          csr_save_id_o    = 1'b1;
          csr_save_cause_o = 1'b1;
        end else if (mret_insn_i) begin
          pc_mux_o           = ctrl_pkg::PC_ERET;
          pc_set_o           = 1'b1;
          csr_restore_mret_o = 1'b1;
        end else if (wfi_insn_i) begin
          ctrl_fsm_ns = WAIT_SLEEP;
        end
      end

      IRQ_TAKEN: begin
        // save IF pc, cause word comes from the interrupt view
        pc_mux_o         = ctrl_pkg::PC_EXC;
        pc_set_o         = 1'b1;
        exc_pc_mux_o     = ctrl_pkg::EXC_PC_IRQ;
        csr_save_if_o    = 1'b1;
        csr_save_cause_o = 1'b1;
        irq_ack_o        = 1'b1;
        exc_ack_o        = 1'b1;
        ctrl_fsm_ns      = DECODE;
      end

      default: begin
        instr_req_o = 1'b0;
        ctrl_fsm_ns = RESET;
      end
    endcase
  end

  ////////////////////////////////////////////////////////////
  // stall control
  ////////////////////////////////////////////////////////////

  // high while the instruction in decode needs more cycles
  assign stall = stall_lsu_i | stall_multdiv_i | stall_jump_i | stall_branch_i;

  assign id_in_ready_o = ~stall & ~halt_if;

  // drop finished instructions, or any when decode is halted
  assign instr_valid_clear_o = ~stall | halt_id;

  assign id_out_valid_o = ~stall & instr_valid_i & ~special_req_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ctrl_fsm_cs <= RESET;
    end else begin
      ctrl_fsm_cs <= ctrl_fsm_ns;
    end
  end

endmodule

`default_nettype wire

/* logic/ctrl_exc_select.sv */
////////////////////////////////////////////////////////////
// exception request and cause selection
// lsu errors are single-cycle pulses and are held one cycle
// so that they are still visible in the flush state
////////////////////////////////////////////////////////////

`default_nettype none
`timescale 1ns/1ps

`include "ctrl_defines.svh"

module ctrl_exc_select (
  input  wire logic                      clk_i,
  input  wire logic                      rst_ni,

  // decoder flags
  input  wire logic                      illegal_insn_i,
  input  wire logic                      ecall_insn_i,
  input  wire logic                      ebrk_insn_i,
  input  wire logic                      mret_insn_i,
  input  wire logic                      wfi_insn_i,
  input  wire logic                      csr_status_i,

  // lsu
  input  wire logic                      load_err_i,
  input  wire logic                      store_err_i,

  input  wire logic [`CTRL_XLEN-1:0]     instr_i,
  input  wire logic [`CTRL_XLEN-1:0]     lsu_addr_last_i,
  input  wire logic [`CTRL_IRQ_ID_W-1:0] irq_id_i,
  input  wire logic                      irq_taken_i,

  output logic                           exc_req_o,
  output logic                           special_req_o,
  output ctrl_pkg::cause_u               exc_cause_o,
  output logic [`CTRL_XLEN-1:0]          csr_mtval_o
);

  logic load_err_q;
  logic store_err_q;
  logic insn_exc;

  // error pulses arrive in decode, the trap is taken in flush
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      load_err_q  <= 1'b0;
      store_err_q <= 1'b0;
    end else begin
      load_err_q  <= load_err_i;
      store_err_q <= store_err_i;
    end
  end

  ////////////////////////////////////////////////////////////
  // requests
  ////////////////////////////////////////////////////////////

  // exceptions raised by the instruction itself
  assign insn_exc = illegal_insn_i | ecall_insn_i | ebrk_insn_i;

  // traps handled in flush
  assign exc_req_o = insn_exc | load_err_q | store_err_q;

  // anything that needs a pipeline flush, live lsu errors included
  assign special_req_o = exc_req_o | mret_insn_i | wfi_insn_i | csr_status_i |
                         load_err_i | store_err_i;

  ////////////////////////////////////////////////////////////
  // cause and trap value
  ////////////////////////////////////////////////////////////

  always_comb begin
    exc_cause_o.exc = ctrl_pkg::EXC_CAUSE_INSN_ADDR_MISA;
    csr_mtval_o     = '0;

    if (irq_taken_i) begin
      // interrupt view, flag on top of the id
      exc_cause_o.irq.irq_flag = 1'b1;
      exc_cause_o.irq.id       = irq_id_i;
    end else if (illegal_insn_i) begin
      // full instruction word as trap value
      exc_cause_o.exc = ctrl_pkg::EXC_CAUSE_ILLEGAL_INSN;
      csr_mtval_o     = instr_i;
    end else if (ecall_insn_i) begin
      exc_cause_o.exc = ctrl_pkg::EXC_CAUSE_ECALL_MMODE;
    end else if (ebrk_insn_i) begin
      // plain breakpoint, there is no debug mode
      exc_cause_o.exc = ctrl_pkg::EXC_CAUSE_BREAKPOINT;
    end else if (store_err_q) begin
      exc_cause_o.exc = ctrl_pkg::EXC_CAUSE_STORE_ACCESS_FAULT;
      csr_mtval_o     = lsu_addr_last_i;
    end else if (load_err_q) begin
      exc_cause_o.exc = ctrl_pkg::EXC_CAUSE_LOAD_ACCESS_FAULT;
      csr_mtval_o     = lsu_addr_last_i;
    end
  end

endmodule

`default_nettype wire

/* logic/ctrl_pkg.sv */
////////////////////////////////////////////////////////////
// types of the decode controller
// cause codes are machine mode only, no debug causes
////////////////////////////////////////////////////////////

`default_nettype none

`include "ctrl_defines.svh"

package ctrl_pkg;

  // fetch address source for the IF stage
  typedef enum logic [1:0] {
    PC_BOOT,
    PC_JUMP,
    PC_EXC,
    PC_ERET
  } pc_sel_e;

  // exception vector select
  typedef enum logic {
    EXC_PC_EXC,
    EXC_PC_IRQ
  } exc_pc_sel_e;

  // synchronous exception codes
  // insn addr misaligned doubles as the idle value
  typedef enum logic [`CTRL_CAUSE_W-1:0] {
    EXC_CAUSE_INSN_ADDR_MISA     = 6'h00,
    EXC_CAUSE_ILLEGAL_INSN       = 6'h02,
    EXC_CAUSE_BREAKPOINT         = 6'h03,
    EXC_CAUSE_LOAD_ACCESS_FAULT  = 6'h05,
    EXC_CAUSE_STORE_ACCESS_FAULT = 6'h07,
    EXC_CAUSE_ECALL_MMODE        = 6'h0B
  } exc_cause_e;

  // interrupt view of the cause word
  typedef struct packed {
    logic                      irq_flag;
    logic [`CTRL_IRQ_ID_W-1:0] id;
  } irq_cause_t;

  // the trap csr reads the same word as either an exception code
  // or an interrupt flag with its id
  typedef union packed {
    exc_cause_e exc;
    irq_cause_t irq;
  } cause_u;

endpackage

`default_nettype wire

/* logic/ctrl_defines.svh */
////////////////////////////////////////////////////////////
// widths shared by the decode controller
// the cause word is one interrupt flag over the interrupt id
////////////////////////////////////////////////////////////

`ifndef CTRL_DEFINES_SVH
`define CTRL_DEFINES_SVH

// data word, sizes instruction, lsu address and trap value
`define CTRL_XLEN 32

// machine interrupt id
`define CTRL_IRQ_ID_W 5

// cause word, flag bit plus id width
`define CTRL_CAUSE_W 6

`endif
